// File: hdl/snoop_pkg.sv
package snoop_pkg;

   // word address into the shared memory, 64 words.
   localparam int ADDR_W = 6;
   localparam int DATA_W = 16;
   localparam int OP_W   = 2;

   // full request word as posted by a core.
   localparam int REQ_W = OP_W + ADDR_W + DATA_W;

   // opcodes; other values complete without touching memory.
   localparam logic [OP_W-1:0] OP_READ  = 2'd1;
   localparam logic [OP_W-1:0] OP_WRITE = 2'd2;

   // one request word, read two ways depending on its opcode.
   // op and addr sit in the same bits in both views.
   typedef union packed {
      struct packed {
         logic [OP_W-1:0]   op;
         logic [ADDR_W-1:0] addr;
         logic [DATA_W-1:0] wdata;   // data to store.
      } wr;
      struct packed {
         logic [OP_W-1:0]   op;
         logic [ADDR_W-1:0] addr;
         logic [DATA_W-1:0] unused;  // don't care on a read.
      } rd;
   } req_word_u;

endpackage

// File: hdl/tree_node.sv
`timescale 1ns/1ns

module tree_node #(
   parameter int TAG_SZ       = 2,
   parameter bit ENABLE_DELAY = 1'b0
) (
   input  logic              clk,
   input  logic              rst_n_i,

   input  logic [TAG_SZ-1:0] left_tag_i,
   input  logic              left_rdy_i,
   output logic              left_ack_o,

   input  logic [TAG_SZ-1:0] right_tag_i,
   input  logic              right_rdy_i,
   output logic              right_ack_o,

   output logic [TAG_SZ-1:0] tag_o,
   output logic              rdy_o,
   input  logic              ack_i
);

   logic pick_right;   // combinational choice.
   logic prio_right;   // on a tie, take the right child.
   logic sel;          // choice the ack is routed by.

   // left wins unless it is idle or the right child is owed a turn.
   assign pick_right = right_rdy_i & (~left_rdy_i | prio_right);

   // after every grant favour the child that was not served.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         prio_right <= 1'b0;
      end else if (ack_i) begin
         prio_right <= ~sel;
      end
   end

   assign left_ack_o  = ack_i & ~sel;
   assign right_ack_o = ack_i & sel;

   if (ENABLE_DELAY) begin : g_delay
      logic              rdy_q;
      logic              sel_q;
      logic [TAG_SZ-1:0] tag_q;

      // a pending entry is held until acked, so the choice cannot move
      // under back-pressure. the valid drops for one cycle after an ack.
      always_ff @(posedge clk or negedge rst_n_i) begin
         if (!rst_n_i) begin
            rdy_q <= 1'b0;
            sel_q <= 1'b0;
         end else if (ack_i) begin
            rdy_q <= 1'b0;
         end else if (!rdy_q) begin
            rdy_q <= left_rdy_i | right_rdy_i;
            sel_q <= pick_right;
         end
      end

      always_ff @(posedge clk) begin
         if (!rdy_q) begin
            tag_q <= pick_right ? right_tag_i : left_tag_i;
         end
      end

      assign sel   = sel_q;
      assign rdy_o = rdy_q;
      assign tag_o = tag_q;
   end else begin : g_comb
      assign sel   = pick_right;
      assign rdy_o = left_rdy_i | right_rdy_i;
      assign tag_o = pick_right ? right_tag_i : left_tag_i;   // straight through.
   end

endmodule

// File: hdl/tag_tree.sv
`timescale 1ns/1ns

module tag_tree #(
   parameter int N_CORES    = 4,
   parameter int TAG_SZ     = 2,
   parameter int DELAY_CONF = 1
) (
   input  logic               clk,
   input  logic               rst_n_i,

   output logic [TAG_SZ-1:0]  tag_o,
   output logic               rdy_o,
   input  logic               ack_i,

   input  logic [N_CORES-1:0] rdy_i,
   output logic [N_CORES-1:0] ack_o
);

   if (N_CORES == 1) begin : g_single
      // one core, nothing to arbitrate.
      assign tag_o    = '0;
      assign rdy_o    = rdy_i[0];
      assign ack_o[0] = ack_i;
   end else begin : g_tree
      // heap layout. leaves are 0..N-1, node k drives slot N+k,
      // and the root ends up in the last slot.
      logic [TAG_SZ-1:0] tags [2*N_CORES-1];
      logic              rdys [2*N_CORES-1];
      logic              acks [2*N_CORES-1];

      for (genvar k = 0; k < N_CORES; k++) begin : g_leaf
         assign tags[k]  = TAG_SZ'(k);   // leaf tag is the core index.
         assign rdys[k]  = rdy_i[k];
         assign ack_o[k] = acks[k];
      end

      for (genvar k = 0; k < N_CORES - 1; k++) begin : g_node
         tree_node #(
            .TAG_SZ       (TAG_SZ),
            .ENABLE_DELAY (((DELAY_CONF == 1) && ($clog2(N_CORES - k) % 2 == 1)) ||
                           (DELAY_CONF == 2))
         ) u_node (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .left_tag_i  (tags[2*k]),
            .left_rdy_i  (rdys[2*k]),
            .left_ack_o  (acks[2*k]),
            .right_tag_i (tags[2*k+1]),
            .right_rdy_i (rdys[2*k+1]),
            .right_ack_o (acks[2*k+1]),
            .tag_o       (tags[N_CORES+k]),
            .rdy_o       (rdys[N_CORES+k]),
            .ack_i       (acks[N_CORES+k])
         );
      end

      assign tag_o              = tags[2*N_CORES-2];
      assign rdy_o              = rdys[2*N_CORES-2];
      assign acks[2*N_CORES-2] = ack_i;   // root ack from the memory.
   end

endmodule

// File: hdl/core_port.sv
`timescale 1ns/1ns

module core_port (
   input  logic                 clk,
   input  logic                 rst_n_i,

   input  logic                 req_valid_i,
   input  snoop_pkg::req_word_u req_word_i,

   output logic                 rdy_o,
   input  logic                 ack_i,
   output snoop_pkg::req_word_u req_word_o,

   input  logic                 done_i,
   output logic                 busy_o
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_REQ  = 2'd1;   // rdy up, waiting for grant.
   localparam logic [1:0] ST_WAIT = 2'd2;   // granted, waiting for done.

   logic [1:0]           state;
   logic                 accept;
   snoop_pkg::req_word_u word_q;

   // busy drops in the very cycle done shows up, so a core may
   // post its next request straight away.
   assign busy_o = (state == ST_REQ) | ((state == ST_WAIT) & ~done_i);
   assign rdy_o  = (state == ST_REQ);
   assign accept = req_valid_i & ~busy_o;   // pulses while busy are dropped.

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (accept) state <= ST_REQ;
            end
            ST_REQ: begin
               if (ack_i) state <= ST_WAIT;   // rdy falls on this edge.
            end
            ST_WAIT: begin
               if (done_i) state <= accept ? ST_REQ : ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // held request word.
   always_ff @(posedge clk) begin
      if (accept) begin
         word_q <= req_word_i;
      end
   end

   assign req_word_o = word_q;

endmodule

// File: hdl/shared_mem.sv
`timescale 1ns/1ns

module shared_mem #(
   parameter int N_CORES = 4,
   parameter int TAG_SZ  = 2
) (
   input  logic                                 clk,
   input  logic                                 rst_n_i,

   input  logic                                 rdy_i,
   input  logic [TAG_SZ-1:0]                    tag_i,
   output logic                                 ack_o,
   input  logic                                 stall_i,

   input  logic [N_CORES*snoop_pkg::REQ_W-1:0]  req_words_i,

   output logic [N_CORES-1:0]                   done_o,
   output logic [snoop_pkg::DATA_W-1:0]         rdata_o
);

   localparam int DEPTH = 2 ** snoop_pkg::ADDR_W;

   logic [snoop_pkg::DATA_W-1:0] mem [DEPTH];
   logic [snoop_pkg::DATA_W-1:0] rdata_q;
   logic [N_CORES-1:0]           done_q;
   snoop_pkg::req_word_u         req;

   // grant whenever the root is ready and memory is not stalled.
   assign ack_o = rdy_i & ~stall_i;

   assign req = req_words_i[tag_i*snoop_pkg::REQ_W +: snoop_pkg::REQ_W];   // granted word.

   // access happens on the ack edge.
   always_ff @(posedge clk) begin
      if (ack_o) begin
         case (req.wr.op)
            snoop_pkg::OP_WRITE: begin
               mem[req.wr.addr] <= req.wr.wdata;
               rdata_q          <= req.wr.wdata;   // echo what was written.
            end
            snoop_pkg::OP_READ: begin
               rdata_q <= mem[req.rd.addr];
            end
            default: begin
               rdata_q <= '0;   // no-op, still completes.
            end
         endcase
      end
   end

   // one-hot done to the granted core, one cycle after ack.
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         done_q <= '0;
      end else begin
         for (int i = 0; i < N_CORES; i++) begin
            done_q[i] <= ack_o && (tag_i == TAG_SZ'(i));
         end
      end
   end

   assign done_o  = done_q;
   assign rdata_o = rdata_q;

endmodule

// File: hdl/cluster_mem_top.sv
`timescale 1ns/1ns

module cluster_mem_top #(
   parameter int N_CORES    = 4,   // power of two.
   parameter int DELAY_CONF = 1
) (
   input  logic                                clk,
   input  logic                                rst_n_i,

   input  logic [N_CORES-1:0]                  req_valid_i,
   input  logic [N_CORES*snoop_pkg::REQ_W-1:0] req_word_i,
   input  logic                                stall_i,

   output logic [N_CORES-1:0]                  busy_o,
   output logic [N_CORES-1:0]                  done_o,
   output logic [snoop_pkg::DATA_W-1:0]        rdata_o
);

   localparam int TAG_SZ = (N_CORES > 1) ? $clog2(N_CORES) : 1;

   logic [N_CORES-1:0]                  port_rdy;
   logic [N_CORES-1:0]                  port_ack;
   logic [N_CORES*snoop_pkg::REQ_W-1:0] port_words;   // held words, core 0 lowest.
   logic [TAG_SZ-1:0]                   root_tag;
   logic                                root_rdy;
   logic                                root_ack;

   for (genvar k = 0; k < N_CORES; k++) begin : g_port
      core_port u_port (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .req_valid_i (req_valid_i[k]),
         .req_word_i  (req_word_i[k*snoop_pkg::REQ_W +: snoop_pkg::REQ_W]),
         .rdy_o       (port_rdy[k]),
         .ack_i       (port_ack[k]),
         .req_word_o  (port_words[k*snoop_pkg::REQ_W +: snoop_pkg::REQ_W]),
         .done_i      (done_o[k]),
         .busy_o      (busy_o[k])
      );
   end

   tag_tree #(
      .N_CORES    (N_CORES),
      .TAG_SZ     (TAG_SZ),
      .DELAY_CONF (DELAY_CONF)
   ) u_tree (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .tag_o   (root_tag),
      .rdy_o   (root_rdy),
      .ack_i   (root_ack),
      .rdy_i   (port_rdy),
      .ack_o   (port_ack)
   );

   shared_mem #(
      .N_CORES (N_CORES),
      .TAG_SZ  (TAG_SZ)
   ) u_mem (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .rdy_i       (root_rdy),
      .tag_i       (root_tag),
      .ack_o       (root_ack),
      .stall_i     (stall_i),
      .req_words_i (port_words),
      .done_o      (done_o),
      .rdata_o     (rdata_o)
   );

endmodule

// File: sim/tb_cluster_mem.sv
`timescale 1ns/1ns

module tb_cluster_mem;

   localparam int N_CORES   = 4;
   localparam int N_ENTRIES = 6;
   localparam int REQ_W     = snoop_pkg::REQ_W;
   localparam int DATA_W    = snoop_pkg::DATA_W;

   logic                     clk;
   logic                     rst_n_i;
   logic [N_CORES-1:0]       req_valid_i;
   logic [N_CORES*REQ_W-1:0] req_word_i;
   logic                     stall_i;
   logic [N_CORES-1:0]       busy_o;
   logic [N_CORES-1:0]       done_o;
   logic [DATA_W-1:0]        rdata_o;

   // phase table. each request byte is {op, addr}, core 0 in the low byte.
   logic [N_CORES-1:0] tbl_mask   [N_ENTRIES];
   logic [31:0]        tbl_req    [N_ENTRIES];
   logic               tbl_stall  [N_ENTRIES];
   int                 tbl_rounds [N_ENTRIES];   // re-requests after done.

   logic [DATA_W-1:0]  ref_mem   [64];            // predicted memory contents.
   logic [1:0]         cur_op    [N_CORES];
   logic [5:0]         cur_addr  [N_CORES];
   logic [DATA_W-1:0]  cur_wdata [N_CORES];
   logic [N_CORES-1:0] pending;
   int                 errors;
   int                 checks;

   cluster_mem_top #(
      .N_CORES    (N_CORES),
      .DELAY_CONF (1)
   ) uut (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .req_valid_i (req_valid_i),
      .req_word_i  (req_word_i),
      .stall_i     (stall_i),
      .busy_o      (busy_o),
      .done_o      (done_o),
      .rdata_o     (rdata_o)
   );

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      end
   endtask

   function automatic logic [7:0] write_code(input logic [5:0] addr);
      return {snoop_pkg::OP_WRITE, addr};
   endfunction

   function automatic logic [7:0] read_code(input logic [5:0] addr);
      return {snoop_pkg::OP_READ, addr};
   endfunction

   task automatic set_entry(input int e, input logic [3:0] mask, input logic [31:0] req,
                            input logic stall, input int rounds);
      tbl_mask[e]   = mask;
      tbl_req[e]    = req;
      tbl_stall[e]  = stall;
      tbl_rounds[e] = rounds;
   endtask

   task automatic post_request(input int k, input int e);
      logic [7:0]        code;
      logic [DATA_W-1:0] wdata;
      code  = tbl_req[e][k*8 +: 8];
      wdata = '0;
      if (code[7:6] == snoop_pkg::OP_WRITE) wdata = DATA_W'($urandom);
      cur_op[k]    = code[7:6];
      cur_addr[k]  = code[5:0];
      cur_wdata[k] = wdata;
      req_word_i[k*REQ_W +: REQ_W] = {code, wdata};
      req_valid_i[k] = 1'b1;   // one-cycle pulse.
      pending[k]     = 1'b1;
   endtask

   // a write answers with its own data, a read with the predicted word.
   task automatic check_response(input int k);
      logic [DATA_W-1:0] expected;
      if (cur_op[k] == snoop_pkg::OP_WRITE) begin
         ref_mem[cur_addr[k]] = cur_wdata[k];
         expected = cur_wdata[k];
      end else begin
         expected = ref_mem[cur_addr[k]];
      end
      check_value("rdata_o", 32'(rdata_o), 32'(expected));
   endtask

   task automatic check_outputs(input logic stalled);
      check_value("busy_o", 32'(busy_o), 32'(pending & ~done_o));
      check_value("done_o", 32'(done_o & ~pending), 32'd0);   // no done without a request.
      if (stalled) check_value("done_o", 32'(done_o), 32'd0);
      check_value("done_o one-hot", 32'($countones(done_o) > 1), 32'd0);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         check_outputs(1'b0);
      end
   endtask

   task automatic run_entry(input int e);
      int                 total;
      int                 served;
      int                 reissued;
      int                 stall_cnt;
      logic               stalled;
      logic [N_CORES-1:0] seen;
      int                 order [$];
      total     = $countones(tbl_mask[e]) + tbl_rounds[e];
      served    = 0;
      reissued  = 0;
      stall_cnt = tbl_stall[e] ? int'($urandom % 6) + 1 : 0;
      for (int k = 0; k < N_CORES; k++) begin
         if (tbl_mask[e][k]) post_request(k, e);
      end
      stalled = (stall_cnt > 0);
      stall_i = stalled;
      if (stall_cnt > 0) stall_cnt--;
      while (served < total) begin
         @(posedge clk);
         #1;
         req_valid_i = '0;
         check_outputs(stalled);
         for (int k = 0; k < N_CORES; k++) begin
            if (done_o[k]) begin
               served++;
               check_response(k);
               pending[k] = 1'b0;
               if (tbl_rounds[e] > 0) begin
                  order.push_back(k);
                  if (order.size() > N_CORES) void'(order.pop_front());
                  if (order.size() == N_CORES) begin
                     seen = '0;
                     foreach (order[i]) seen[order[i]] = 1'b1;
                     check_value("done_o window", 32'(seen), 32'hf);
                  end
               end
               if (reissued < tbl_rounds[e]) begin
                  post_request(k, e);   // straight back into the queue.
                  reissued++;
               end
               if (tbl_stall[e] && served < total) stall_cnt = int'($urandom % 6) + 1;
            end
         end
         stalled = (stall_cnt > 0);
         stall_i = stalled;
         if (stall_cnt > 0) stall_cnt--;
      end
      stall_i = 1'b0;
   endtask

   initial begin
      repeat (N_ENTRIES * 40 + 100) @(posedge clk);
      $display("timeout: the requests did not all complete within %0d cycles",
               N_ENTRIES * 40 + 100);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      clk         = 1'b0;
      rst_n_i     = 1'b0;
      req_valid_i = '0;
      req_word_i  = '0;
      stall_i     = 1'b0;
      pending     = '0;
      errors      = 0;
      checks      = 0;
      void'($urandom(81));
      // reads only hit addresses written in an earlier entry.
      set_entry(0, 4'b0001, {8'h00, 8'h00, 8'h00, write_code(6'd5)}, 1'b0, 0);
      set_entry(1, 4'b0001, {8'h00, 8'h00, 8'h00, read_code(6'd5)}, 1'b0, 0);
      set_entry(2, 4'b1111, {read_code(6'd5), write_code(6'd20), read_code(6'd5),
                             write_code(6'd10)}, 1'b0, 0);
      set_entry(3, 4'b1111, {read_code(6'd20), write_code(6'd31), read_code(6'd10),
                             write_code(6'd30)}, 1'b0, 12);
      set_entry(4, 4'b1111, {write_code(6'd30), read_code(6'd20), write_code(6'd11),
                             read_code(6'd10)}, 1'b1, 0);
      set_entry(5, 4'b0110, {8'h00, read_code(6'd30), read_code(6'd11), 8'h00}, 1'b1, 0);
      repeat (5) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      idle_cycles(3);   // outputs stay quiet after reset.
      for (int e = 0; e < N_ENTRIES; e++) begin
         run_entry(e);
         idle_cycles(2);
      end
      $display("%0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: sources.f
hdl/snoop_pkg.sv
hdl/tree_node.sv
hdl/tag_tree.sv
hdl/core_port.sv
hdl/shared_mem.sv
hdl/cluster_mem_top.sv
sim/tb_cluster_mem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cluster_mem
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
